/* Makefile */
TOP = circuit_layout_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi
	@echo "simulation passed"

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* circuit_layout_config.svh */
`ifndef CIRCUIT_LAYOUT_CONFIG_SVH
`define CIRCUIT_LAYOUT_CONFIG_SVH

// full screen in pixels
`define CL_SCREEN_W 640
`define CL_SCREEN_H 480

// side and top/bottom margins
`define CL_MARGIN_X 20
`define CL_MARGIN_Y 5

// drawable area left inside the margins
`define CL_USABLE_W (`CL_SCREEN_W - 2 * `CL_MARGIN_X)
`define CL_USABLE_H (`CL_SCREEN_H - 2 * `CL_MARGIN_Y)

// element sprite and junction dot
`define CL_SPRITE_W 44
`define CL_DOT_W 6
`define CL_DOT_H 10

// table depths
// 12 elements keep the slot pitch at 50, above the sprite width
`define CL_MAX_ELEMENTS 12
`define CL_MAX_NODES 32

`endif

/* circuit_layout_pkg.sv */
package circuit_layout_pkg;

`include "circuit_layout_config.svh"

	// table indices
	typedef logic [$clog2(`CL_MAX_NODES)-1:0] node_idx_t;
	typedef logic [$clog2(`CL_MAX_ELEMENTS)-1:0] elem_idx_t;

	// screen coordinates
	typedef logic [9:0] xpos_t;
	typedef logic [8:0] ypos_t;

	// element type code, same as the loading record
	typedef enum logic [1:0] {
		ELEM_VSRC  = 2'd0,
		ELEM_ISRC  = 2'd1,
		ELEM_RES   = 2'd2,
		ELEM_UNDEF = 2'd3
	} element_type_e;

	// one loaded element, node A in the top bits
	typedef struct packed {
		node_idx_t     node_a;
		node_idx_t     node_b;
		element_type_e kind;
		logic [9:0]    exponent;
		logic [9:0]    value;
	} element_rec_t;

	// shape code of a draw command
	typedef enum logic [8:0] {
		CMD_LINE_FILLED = 9'd0,
		CMD_LINE_DASHED = 9'd1,
		CMD_SPRITE_V    = 9'd2,
		CMD_SPRITE_I    = 9'd3,
		CMD_SPRITE_R    = 9'd4,
		CMD_DOT         = 9'd5
	} draw_kind_e;

	// draw processor record without the valid bit
	typedef struct packed {
		draw_kind_e kind;
		logic [8:0] height;
		logic [9:0] width;
		ypos_t      top;
		xpos_t      left;
	} draw_cmd_t;

	// command generator sequencing
	typedef enum logic [3:0] {
		GEN_IDLE, GEN_PLAN, GEN_PLAN_REL, GEN_LINE, GEN_ROW_A, GEN_ROW_B,
		GEN_SPRITE, GEN_DOT_A, GEN_DOT_B, GEN_CMD_HI, GEN_CMD_LO, GEN_RUN_DONE
	} gen_state_e;

endpackage

/* circuit_layout_sva.sv */
`timescale 1ns/1ps

module circuit_layout_sva import circuit_layout_pkg::*; (
	input logic      clk,
	input logic      rst,
	input logic      run_req,
	input logic      run_ack,
	input logic      plan_req,
	input logic      node_ack,
	input logic      layout_ack,
	input logic      cmd_req,
	input draw_cmd_t cmd,
	input logic      cmd_ack
);

	// run_ack answers the run_req seen one cycle before
	run_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(run_ack) |-> $past(run_req)) else $error("run_ack rose without run_req");

	// every other ack rises only while its req is up
	cmd_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(cmd_ack) |-> cmd_req) else $error("cmd_ack rose without cmd_req");
	node_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(node_ack) |-> plan_req) else $error("node_ack rose without plan_req");
	layout_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(layout_ack) |-> plan_req) else $error("layout_ack rose without plan_req");

	// payload frozen while the command waits for its ack
	cmd_stable: assert property (@(posedge clk) disable iff (rst)
		(cmd_req && !cmd_ack) |=> $stable(cmd)) else $error("cmd changed while pending");

	// run ack released only after run_req went low
	run_ack_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(run_ack) |-> $past(!run_req)) else $error("run_ack fell with run_req high");

endmodule

bind circuit_layout_top circuit_layout_sva u_sva (
	.clk(clk), .rst(rst),
	.run_req(run_req), .run_ack(run_ack),
	.plan_req(plan_req), .node_ack(node_ack), .layout_ack(layout_ack),
	.cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack)
);

/* circuit_layout_tb.sv */
`timescale 1ns/1ps
`include "circuit_layout_config.svh"

module circuit_layout_tb import circuit_layout_pkg::*; ();

	logic clk;
	logic rst;
	logic elem_req;
	element_rec_t elem_rec;
	logic elem_ack;
	logic run_req;
	logic run_ack;
	logic cmd_req;
	draw_cmd_t cmd;
	logic cmd_ack;

	// reference model state
	element_rec_t model_elems[$];
	draw_cmd_t exp_q[$];
	draw_cmd_t got_q[$];

	logic [31:0] rng_state;
	int checks;
	int errors;
	int tests;
	int mark;
	int set_size;
	int filled;

	circuit_layout_top UUT (
		.clk(clk), .rst(rst),
		.elem_req(elem_req), .elem_rec(elem_rec), .elem_ack(elem_ack),
		.run_req(run_req), .run_ack(run_ack),
		.cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack)
	);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// xorshift32, one step per call
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	function automatic element_rec_t make_element(input int a, input int b,
			input element_type_e kind);
		element_rec_t rec;
		rec.node_a = node_idx_t'(a);
		rec.node_b = node_idx_t'(b);
		rec.kind = kind;
		rec.exponent = 10'(next_rand());
		rec.value = 10'(next_rand());
		return rec;
	endfunction

	// valid kinds only, nodes across the whole range
	function automatic element_rec_t random_element();
		return make_element(int'(next_rand() % `CL_MAX_NODES),
			int'(next_rand() % `CL_MAX_NODES),
			element_type_e'(2'(next_rand() % 3)));
	endfunction

	// reset also empties the element table, so the model restarts
	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		elem_req = 1'b0;
		run_req = 1'b0;
		cmd_ack = 1'b0;
		elem_rec = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		model_elems.delete();
	endtask

	task automatic load_element(input element_rec_t rec);
		int wait_cnt;
		@(negedge clk);
		elem_rec = rec;
		elem_req = 1'b1;
		wait_cnt = 0;
		while (!elem_ack) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > 20) begin
				abort_on_timeout("elem_ack never rose after elem_req");
			end
		end
		elem_req = 1'b0;
		wait_cnt = 0;
		while (elem_ack) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > 20) begin
				abort_on_timeout("elem_ack stayed high after elem_req fell");
			end
		end
		// undefined or overflow entries are dropped
		if (rec.kind != ELEM_UNDEF && model_elems.size() < `CL_MAX_ELEMENTS) begin
			model_elems.push_back(rec);
		end
	endtask

	task automatic push_cmd(input draw_kind_e kind, input int height, input int width,
			input int top, input int left);
		draw_cmd_t c;
		c.kind = kind;
		c.height = 9'(height);
		c.width = 10'(width);
		c.top = ypos_t'(top);
		c.left = xpos_t'(left);
		exp_q.push_back(c);
	endtask

	// expected stream straight from the layout rules
	task automatic build_expected();
		int deg [`CL_MAX_NODES];
		int row [`CL_MAX_NODES];
		int nn;
		int ne;
		int row_pitch;
		int slot_pitch;
		int cx;
		int ra;
		int rb;
		draw_kind_e sk;
		exp_q.delete();
		ne = model_elems.size();
		nn = 0;
		foreach (deg[n]) begin
			deg[n] = 0;
		end
		foreach (model_elems[i]) begin
			deg[model_elems[i].node_a]++;
			deg[model_elems[i].node_b]++;
			if (int'(model_elems[i].node_a) + 1 > nn) begin
				nn = int'(model_elems[i].node_a) + 1;
			end
			if (int'(model_elems[i].node_b) + 1 > nn) begin
				nn = int'(model_elems[i].node_b) + 1;
			end
		end
		if (ne > 0) begin
			row_pitch = (`CL_SCREEN_H - 2 * `CL_MARGIN_Y) / (nn + 1);
			slot_pitch = (`CL_SCREEN_W - 2 * `CL_MARGIN_X) / ne;
			for (int n = 0; n < nn; n++) begin
				row[n] = `CL_MARGIN_Y + (n + 1) * row_pitch;
				push_cmd((deg[n] >= 2) ? CMD_LINE_FILLED : CMD_LINE_DASHED, 1,
					`CL_SCREEN_W - 2 * `CL_MARGIN_X, row[n], `CL_MARGIN_X);
			end
			foreach (model_elems[i]) begin
				cx = `CL_MARGIN_X + i * slot_pitch + slot_pitch / 2;
				ra = row[model_elems[i].node_a];
				rb = row[model_elems[i].node_b];
				case (model_elems[i].kind)
					ELEM_VSRC: sk = CMD_SPRITE_V;
					ELEM_ISRC: sk = CMD_SPRITE_I;
					default: sk = CMD_SPRITE_R;
				endcase
				push_cmd(sk, (ra < rb) ? rb - ra : ra - rb, `CL_SPRITE_W,
					(ra < rb) ? ra : rb, cx - `CL_SPRITE_W / 2);
				push_cmd(CMD_DOT, `CL_DOT_H, `CL_DOT_W, ra - `CL_DOT_H / 2, cx - `CL_DOT_W / 2);
				push_cmd(CMD_DOT, `CL_DOT_H, `CL_DOT_W, rb - `CL_DOT_H / 2, cx - `CL_DOT_W / 2);
			end
		end
	endtask

	// run handshake, collecting commands with random ack delays
	task automatic run_circuit(input int max_delay);
		int wait_cnt;
		int ack_cnt;
		int delay;
		draw_cmd_t held;
		got_q.delete();
		@(negedge clk);
		run_req = 1'b1;
		wait_cnt = 0;
		while (!run_ack) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > 4000) begin
				abort_on_timeout("run_ack never rose and no command arrived");
			end
			if (cmd_req && !run_ack) begin
				held = cmd;
				got_q.push_back(held);
				delay = int'(next_rand() % (max_delay + 1));
				// payload must hold while ack is withheld
				repeat (delay) begin
					@(negedge clk);
					check_value("cmd", 64'(cmd), 64'(held));
					check_value("cmd_req", 64'(cmd_req), 64'd1);
				end
				cmd_ack = 1'b1;
				ack_cnt = 0;
				while (cmd_req) begin
					@(negedge clk);
					ack_cnt++;
					if (ack_cnt > 20) begin
						abort_on_timeout("cmd_req stayed high after cmd_ack rose");
					end
				end
				cmd_ack = 1'b0;
				wait_cnt = 0;
			end
		end
		run_req = 1'b0;
		wait_cnt = 0;
		while (run_ack) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > 20) begin
				abort_on_timeout("run_ack stayed high after run_req fell");
			end
		end
	endtask

	task automatic compare_stream();
		check_value("command count", 64'(got_q.size()), 64'(exp_q.size()));
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
			check_value($sformatf("cmd[%0d]", i), 64'(got_q[i]), 64'(exp_q[i]));
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
	endtask

	initial begin
		rst = 1'b1;
		elem_req = 1'b0;
		elem_rec = '0;
		run_req = 1'b0;
		cmd_ack = 1'b0;
		rng_state = 32'd74;
		checks = 0;
		errors = 0;
		tests = 0;

		// idle outputs, then an empty run
		apply_reset();
		mark = errors;
		check_value("elem_ack", 64'(elem_ack), 64'd0);
		check_value("run_ack", 64'(run_ack), 64'd0);
		check_value("cmd_req", 64'(cmd_req), 64'd0);
		build_expected();
		run_circuit(0);
		compare_stream();
		report_test("reset and empty run", mark);

		// one resistor, positions worked out by hand
		apply_reset();
		mark = errors;
		load_element(make_element(0, 1, ELEM_RES));
		run_circuit(0);
		exp_q.delete();
		push_cmd(CMD_LINE_DASHED, 1, 600, 161, 20);
		push_cmd(CMD_LINE_DASHED, 1, 600, 317, 20);
		push_cmd(CMD_SPRITE_R, 156, 44, 161, 298);
		push_cmd(CMD_DOT, 10, 6, 156, 317);
		push_cmd(CMD_DOT, 10, 6, 312, 317);
		compare_stream();
		report_test("single resistor", mark);

		mark = errors;
		for (int s = 0; s < 8; s++) begin
			apply_reset();
			set_size = 1 + int'(next_rand() % `CL_MAX_ELEMENTS);
			repeat (set_size) load_element(random_element());
			build_expected();
			run_circuit(0);
			compare_stream();
		end
		report_test("random sets", mark);

		// undefined entries sit on node 31, above every valid node
		mark = errors;
		for (int s = 0; s < 4; s++) begin
			apply_reset();
			set_size = 1 + int'(next_rand() % 6);
			repeat (set_size) begin
				load_element(make_element(31, int'(next_rand() % 32), ELEM_UNDEF));
				load_element(make_element(int'(next_rand() % 16), int'(next_rand() % 16),
					element_type_e'(2'(next_rand() % 3))));
			end
			build_expected();
			run_circuit(0);
			compare_stream();
		end
		report_test("undefined elements dropped", mark);

		mark = errors;
		for (int s = 0; s < 6; s++) begin
			apply_reset();
			set_size = 1 + int'(next_rand() % `CL_MAX_ELEMENTS);
			repeat (set_size) load_element(random_element());
			build_expected();
			run_circuit(7);
			compare_stream();
		end
		report_test("cmd_ack back-pressure", mark);

		// degrees 1 2 2 2 0 1 over nodes 0 to 5
		apply_reset();
		mark = errors;
		load_element(make_element(0, 1, ELEM_VSRC));
		load_element(make_element(1, 2, ELEM_RES));
		load_element(make_element(2, 3, ELEM_ISRC));
		load_element(make_element(3, 5, ELEM_RES));
		build_expected();
		run_circuit(3);
		compare_stream();
		filled = 0;
		foreach (got_q[i]) begin
			if (got_q[i].kind == CMD_LINE_FILLED) begin
				filled++;
			end
		end
		check_value("filled line count", 64'(filled), 64'd3);
		report_test("line style by degree", mark);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* circuit_layout_top.sv */
`timescale 1ns/1ps

module circuit_layout_top import circuit_layout_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         elem_req,
	input  element_rec_t elem_rec,
	output logic         elem_ack,
	input  logic         run_req,
	output logic         run_ack,
	output logic         cmd_req,
	output draw_cmd_t    cmd,
	input  logic         cmd_ack
);

	logic [$bits(elem_idx_t):0] num_elements;
	logic [$bits(node_idx_t):0] num_nodes;

	// planning handshake, one req to two acks
	logic plan_req;
	logic node_ack;
	logic layout_ack;

	// element table read ports
	elem_idx_t scan_idx;
	element_rec_t scan_rec;
	elem_idx_t gen_idx;
	element_rec_t gen_rec;

	// result lookups
	node_idx_t deg_idx;
	logic [5:0] deg;
	node_idx_t node_sel;
	ypos_t node_y;
	elem_idx_t elem_sel;
	xpos_t elem_x;

	element_store u_store (
		.clk(clk), .rst(rst),
		.elem_req(elem_req), .elem_rec(elem_rec), .elem_ack(elem_ack),
		.rd_idx_a(scan_idx), .rd_idx_b(gen_idx),
		.rd_rec_a(scan_rec), .rd_rec_b(gen_rec),
		.num_elements(num_elements), .num_nodes(num_nodes)
	);

	// degree count and layout run side by side
	node_table_builder u_builder (
		.clk(clk), .rst(rst),
		.plan_req(plan_req), .node_ack(node_ack),
		.num_elements(num_elements),
		.rd_idx(scan_idx), .rd_rec(scan_rec),
		.deg_idx(deg_idx), .deg(deg)
	);

	layout_planner u_planner (
		.clk(clk), .rst(rst),
		.plan_req(plan_req), .layout_ack(layout_ack),
		.num_elements(num_elements), .num_nodes(num_nodes),
		.node_sel(node_sel), .node_y(node_y),
		.elem_sel(elem_sel), .elem_x(elem_x)
	);

	draw_command_gen u_gen (
		.clk(clk), .rst(rst),
		.run_req(run_req), .run_ack(run_ack),
		.plan_req(plan_req), .node_ack(node_ack), .layout_ack(layout_ack),
		.num_elements(num_elements), .num_nodes(num_nodes),
		.rd_idx(gen_idx), .rd_rec(gen_rec),
		.deg_idx(deg_idx), .deg(deg),
		.node_sel(node_sel), .node_y(node_y),
		.elem_sel(elem_sel), .elem_x(elem_x),
		.cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack)
	);

endmodule

/* draw_command_gen.sv */
`timescale 1ns/1ps
`include "circuit_layout_config.svh"

module draw_command_gen import circuit_layout_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       run_req,
	output logic                       run_ack,
	output logic                       plan_req,
	input  logic                       node_ack,
	input  logic                       layout_ack,
	input  logic [$bits(elem_idx_t):0] num_elements,
	input  logic [$bits(node_idx_t):0] num_nodes,
	output elem_idx_t                  rd_idx,
	input  element_rec_t               rd_rec,
	output node_idx_t                  deg_idx,
	input  logic [5:0]                 deg,
	output node_idx_t                  node_sel,
	input  ypos_t                      node_y,
	output elem_idx_t                  elem_sel,
	input  xpos_t                      elem_x,
	output logic                       cmd_req,
	output draw_cmd_t                  cmd,
	input  logic                       cmd_ack
);

	gen_state_e state;
	// command in flight, picks the next step
	gen_state_e issued;
	node_idx_t node_cnt;
	elem_idx_t elem_cnt;
	ypos_t row_a;
	ypos_t row_b;
	draw_cmd_t next_cmd;
	logic issuing;
	logic last_node;
	logic last_elem;
	logic no_elems;

	assign rd_idx = elem_cnt;
	assign elem_sel = elem_cnt;
	assign deg_idx = node_cnt;
	assign run_ack = (state == GEN_RUN_DONE);
	assign no_elems = (num_elements == '0);
	assign last_node = ({1'b0, node_cnt} == num_nodes - 1'b1);
	assign last_elem = ({1'b0, elem_cnt} == num_elements - 1'b1);
	assign issuing = (state == GEN_LINE) || (state == GEN_SPRITE)
		|| (state == GEN_DOT_A) || (state == GEN_DOT_B);

	// one row lookup port, terminals fetched on separate cycles
	always_comb begin
		case (state)
			GEN_ROW_A: node_sel = rd_rec.node_a;
			GEN_ROW_B: node_sel = rd_rec.node_b;
			default: node_sel = node_cnt;
		endcase
	end

	always_comb begin
		next_cmd = '0;
		case (state)
			GEN_LINE: begin
				// shared node drawn solid
				next_cmd.kind = (deg >= 6'd2) ? CMD_LINE_FILLED : CMD_LINE_DASHED;
				next_cmd.height = 9'd1;
				next_cmd.width = 10'(`CL_USABLE_W);
				next_cmd.top = node_y;
				next_cmd.left = xpos_t'(`CL_MARGIN_X);
			end
			GEN_SPRITE: begin
				case (rd_rec.kind)
					ELEM_VSRC: next_cmd.kind = CMD_SPRITE_V;
					ELEM_ISRC: next_cmd.kind = CMD_SPRITE_I;
					default: next_cmd.kind = CMD_SPRITE_R;
				endcase
				next_cmd.left = elem_x - xpos_t'(`CL_SPRITE_W / 2);
				next_cmd.width = 10'(`CL_SPRITE_W);
				// sprite spans from the upper row down to the lower one
				if (row_a < row_b) begin
					next_cmd.top = row_a;
					next_cmd.height = row_b - row_a;
				end else begin
					next_cmd.top = row_b;
					next_cmd.height = row_a - row_b;
				end
			end
			GEN_DOT_A, GEN_DOT_B: begin
				next_cmd.kind = CMD_DOT;
				next_cmd.left = elem_x - xpos_t'(`CL_DOT_W / 2);
				next_cmd.width = 10'(`CL_DOT_W);
				next_cmd.height = 9'(`CL_DOT_H);
				// dot centered on the node line
				next_cmd.top = ((state == GEN_DOT_A) ? row_a : row_b)
					- ypos_t'(`CL_DOT_H / 2);
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= GEN_IDLE;
			issued <= GEN_IDLE;
			plan_req <= 1'b0;
			cmd_req <= 1'b0;
			node_cnt <= '0;
			elem_cnt <= '0;
		end else begin
			case (state)
				GEN_IDLE: begin
					if (run_req) begin
						plan_req <= 1'b1;
						state <= GEN_PLAN;
					end
				end
				GEN_PLAN: begin
					// both planners must finish
					if (node_ack && layout_ack) begin
						plan_req <= 1'b0;
						state <= GEN_PLAN_REL;
					end
				end
				GEN_PLAN_REL: begin
					if (!node_ack && !layout_ack) begin
						node_cnt <= '0;
						elem_cnt <= '0;
						state <= no_elems ? GEN_RUN_DONE : GEN_LINE;
					end
				end
				GEN_ROW_A: begin
					state <= GEN_ROW_B;
				end
				GEN_ROW_B: begin
					state <= GEN_SPRITE;
				end
				GEN_LINE, GEN_SPRITE, GEN_DOT_A, GEN_DOT_B: begin
					cmd_req <= 1'b1;
					issued <= state;
					state <= GEN_CMD_HI;
				end
				GEN_CMD_HI: begin
					if (cmd_ack) begin
						cmd_req <= 1'b0;
						state <= GEN_CMD_LO;
					end
				end
				GEN_CMD_LO: begin
					// next command only once ack is back low
					if (!cmd_ack) begin
						case (issued)
							GEN_LINE: begin
								if (last_node) begin
									state <= GEN_ROW_A;
								end else begin
									node_cnt <= node_cnt + 1'b1;
									state <= GEN_LINE;
								end
							end
							GEN_SPRITE: state <= GEN_DOT_A;
							GEN_DOT_A: state <= GEN_DOT_B;
							default: begin
								if (last_elem) begin
									state <= GEN_RUN_DONE;
								end else begin
									elem_cnt <= elem_cnt + 1'b1;
									state <= GEN_ROW_A;
								end
							end
						endcase
					end
				end
				GEN_RUN_DONE: begin
					if (!run_req) begin
						state <= GEN_IDLE;
					end
				end
				default: begin
					state <= GEN_IDLE;
				end
			endcase
		end
	end

	// rows of the current element and the held command payload
	always_ff @(posedge clk) begin
		if (state == GEN_ROW_A) begin
			row_a <= node_y;
		end
		if (state == GEN_ROW_B) begin
			row_b <= node_y;
		end
		if (issuing) begin
			cmd <= next_cmd;
		end
	end

endmodule

/* element_store.sv */
`timescale 1ns/1ps
`include "circuit_layout_config.svh"

module element_store import circuit_layout_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       elem_req,
	input  element_rec_t               elem_rec,
	output logic                       elem_ack,
	input  elem_idx_t                  rd_idx_a,
	input  elem_idx_t                  rd_idx_b,
	output element_rec_t               rd_rec_a,
	output element_rec_t               rd_rec_b,
	output logic [$bits(elem_idx_t):0] num_elements,
	output logic [$bits(node_idx_t):0] num_nodes
);

	// elements in load order
	element_rec_t elem_table [`CL_MAX_ELEMENTS];

	logic take;
	logic table_full;
	logic store_ok;
	logic [$bits(node_idx_t):0] span_a;
	logic [$bits(node_idx_t):0] span_b;
	logic [$bits(node_idx_t):0] span_hi;

	// first cycle of a new request, before ack goes up
	assign take = elem_req && !elem_ack;
	assign table_full = (num_elements == `CL_MAX_ELEMENTS);

	// undefined types and overflow are acked but dropped
	assign store_ok = take && !table_full && (elem_rec.kind != ELEM_UNDEF);

	// node count each terminal would need
	assign span_a = {1'b0, elem_rec.node_a} + 1'b1;
	assign span_b = {1'b0, elem_rec.node_b} + 1'b1;
	assign span_hi = (span_a > span_b) ? span_a : span_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			elem_ack <= 1'b0;
			num_elements <= '0;
			num_nodes <= '0;
		end else begin
			// ack mirrors req one cycle late, both edges
			elem_ack <= elem_req;
			if (store_ok) begin
				num_elements <= num_elements + 1'b1;
				// highest node seen so far, plus one
				if (span_hi > num_nodes) begin
					num_nodes <= span_hi;
				end
			end
		end
	end

	// table write at the current count
	always_ff @(posedge clk) begin
		if (store_ok) begin
			elem_table[elem_idx_t'(num_elements)] <= elem_rec;
		end
	end

	// port a feeds the degree scan
	assign rd_rec_a = elem_table[rd_idx_a];

	// port b feeds the command generator
	assign rd_rec_b = elem_table[rd_idx_b];

endmodule

/* layout_planner.sv */
`timescale 1ns/1ps
`include "circuit_layout_config.svh"

module layout_planner import circuit_layout_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       plan_req,
	output logic                       layout_ack,
	input  logic [$bits(elem_idx_t):0] num_elements,
	input  logic [$bits(node_idx_t):0] num_nodes,
	input  node_idx_t                  node_sel,
	output ypos_t                      node_y,
	input  elem_idx_t                  elem_sel,
	output xpos_t                      elem_x
);

	typedef enum logic [2:0] {
		P_IDLE,
		P_DIV_ROW,
		P_DIV_SLOT,
		P_FILL,
		P_DONE
	} plan_state_e;

	plan_state_e state;

	// shared divider, one subtraction per cycle
	logic [9:0] rem;
	logic [9:0] divisor;
	logic [9:0] quo;
	logic dividing;
	logic div_step;

	ypos_t row_pitch;
	xpos_t slot_pitch;
	ypos_t y_acc;
	xpos_t x_acc;
	node_idx_t fill_idx;

	// node row and element center tables
	ypos_t node_y_tab [`CL_MAX_NODES];
	xpos_t elem_x_tab [`CL_MAX_ELEMENTS];

	assign dividing = (state == P_DIV_ROW) || (state == P_DIV_SLOT);
	// zero divisor ends at once with a zero quotient
	assign div_step = dividing && (divisor != '0) && (rem >= divisor);
	assign layout_ack = (state == P_DONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= P_IDLE;
			fill_idx <= '0;
		end else begin
			if (div_step) begin
				rem <= rem - divisor;
				quo <= quo + 1'b1;
			end
			case (state)
				P_IDLE: begin
					if (plan_req) begin
						// rows leave one pitch above and below the node lines
						rem <= 10'(`CL_USABLE_H);
						divisor <= 10'(num_nodes) + 10'd1;
						quo <= '0;
						state <= P_DIV_ROW;
					end
				end
				P_DIV_ROW: begin
					if (!div_step) begin
						row_pitch <= ypos_t'(quo);
						rem <= 10'(`CL_USABLE_W);
						divisor <= 10'(num_elements);
						quo <= '0;
						state <= P_DIV_SLOT;
					end
				end
				P_DIV_SLOT: begin
					if (!div_step) begin
						slot_pitch <= xpos_t'(quo);
						// node 0 row and element 0 center
						y_acc <= ypos_t'(`CL_MARGIN_Y) + row_pitch;
						x_acc <= xpos_t'(`CL_MARGIN_X) + (quo >> 1);
						fill_idx <= '0;
						state <= P_FILL;
					end
				end
				P_FILL: begin
					y_acc <= y_acc + row_pitch;
					x_acc <= x_acc + slot_pitch;
					fill_idx <= fill_idx + 1'b1;
					if (fill_idx == node_idx_t'(`CL_MAX_NODES - 1)) begin
						state <= P_DONE;
					end
				end
				P_DONE: begin
					if (!plan_req) begin
						state <= P_IDLE;
					end
				end
				default: begin
					state <= P_IDLE;
				end
			endcase
		end
	end

	// entries past the counts are never looked up
	always_ff @(posedge clk) begin
		if (state == P_FILL) begin
			node_y_tab[fill_idx] <= y_acc;
			if (fill_idx < `CL_MAX_ELEMENTS) begin
				elem_x_tab[elem_idx_t'(fill_idx)] <= x_acc;
			end
		end
	end

	assign node_y = node_y_tab[node_sel];
	assign elem_x = elem_x_tab[elem_sel];

endmodule

/* node_table_builder.sv */
`timescale 1ns/1ps
`include "circuit_layout_config.svh"

module node_table_builder import circuit_layout_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       plan_req,
	output logic                       node_ack,
	input  logic [$bits(elem_idx_t):0] num_elements,
	output elem_idx_t                  rd_idx,
	input  element_rec_t               rd_rec,
	input  node_idx_t                  deg_idx,
	output logic [5:0]                 deg
);

	typedef enum logic [1:0] {
		B_IDLE,
		B_CLEAR,
		B_SCAN,
		B_DONE
	} build_state_e;

	build_state_e state;
	elem_idx_t scan_idx;
	logic last_elem;

	// terminals per node, 24 at most
	logic [5:0] deg_tab [`CL_MAX_NODES];

	assign rd_idx = scan_idx;
	assign deg = deg_tab[deg_idx];
	assign node_ack = (state == B_DONE);
	assign last_elem = ({1'b0, scan_idx} == num_elements - 1'b1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= B_IDLE;
			scan_idx <= '0;
		end else begin
			case (state)
				B_IDLE: begin
					if (plan_req) begin
						state <= B_CLEAR;
					end
				end
				B_CLEAR: begin
					scan_idx <= '0;
					// empty table goes straight to ack
					state <= (num_elements == '0) ? B_DONE : B_SCAN;
				end
				B_SCAN: begin
					// one element per cycle
					if (last_elem) begin
						state <= B_DONE;
					end else begin
						scan_idx <= scan_idx + 1'b1;
					end
				end
				B_DONE: begin
					// hold ack until the request is withdrawn
					if (!plan_req) begin
						state <= B_IDLE;
					end
				end
				default: begin
					state <= B_IDLE;
				end
			endcase
		end
	end

	// count both terminals of the element under scan
	// a self-loop matches twice and adds two
	always_ff @(posedge clk) begin
		for (int n = 0; n < `CL_MAX_NODES; n++) begin
			if (state == B_CLEAR) begin
				deg_tab[n] <= '0;
			end else if (state == B_SCAN) begin
				deg_tab[n] <= deg_tab[n]
					+ 6'(rd_rec.node_a == node_idx_t'(n))
					+ 6'(rd_rec.node_b == node_idx_t'(n));
			end
		end
	end

endmodule

/* sources.f */
+incdir+.
circuit_layout_pkg.sv
element_store.sv
node_table_builder.sv
layout_planner.sv
draw_command_gen.sv
circuit_layout_top.sv
circuit_layout_sva.sv
circuit_layout_tb.sv
